/* design/fpm_macros.svh */
// width and limit constants for the exponent unit
// included by the packages and by any module that sizes its own signals

`ifndef FPM_MACROS_SVH
`define FPM_MACROS_SVH

// operand exponent width, as seen on the request port
`define FPM_EXP_W 8

// alignment shift counter width
`define FPM_FIC_W 6

// exponent difference at or above this sets g
// (no alignment is done, one operand is simply dropped)
`define FPM_ALIGN_LIMIT 40

`endif

/* design/fpm_op_pkg.sv */
// operation codes and the decoded operation class
// op_code_e arrives with the request, op_sel_t is the decoder output

package fpm_op_pkg;

	// bit 2 set means floating point
	typedef enum logic [2:0] {
		ad = 3'd0,
		sd = 3'd1,
		mw = 3'd2,
		dw = 3'd3,
		af = 3'd4,
		sf = 3'd5,
		mf = 3'd6,
		df = 3'd7
	} op_code_e;

	// one-hot operation plus class bits
	typedef struct packed {
		logic ad;
		logic sd;
		logic mw;
		logic dw;
		logic af;
		logic sf;
		logic mf;
		logic df;
		// any floating point operation
		logic ff;
		// any fixed point operation
		logic ss;
	} op_sel_t;

endpackage

/* design/fpm_data_pkg.sv */
// data types on the request and result ports and between the blocks
// exponent widths follow the macros header

`include "fpm_macros.svh"

package fpm_data_pkg;

	// operand exponent
	typedef logic signed [`FPM_EXP_W-1:0] opexp_t;

	// internal exponent, two guard bits above the operand range
	typedef logic signed [`FPM_EXP_W+1:0] exp_t;

	typedef struct packed {
		fpm_op_pkg::op_code_e op;
		opexp_t exp_a;
		opexp_t exp_b;
	} exp_req_t;

	// one strobe per microstep
	typedef struct packed {
		logic load;
		logic eval;
		logic step;
		logic fin;
	} phase_t;

	typedef struct packed {
		opexp_t exp;
		logic g;
		logic wdt;
		logic wt;
		// underflow
		logic fi1;
		// overflow
		logic fi2;
		logic ff;
		logic [`FPM_FIC_W-1:0] shifts;
	} exp_res_t;

endpackage

/* design/fpm_op_regs.sv */
// request register and operation decoder
// captures the request when start is seen while idle and holds it for the
// whole operation
// the class outputs steer the exponent path and indicators

`timescale 1ns/1ps

module fpm_op_regs(
	input logic clk_sys,
	input logic _0_f,
	input logic start,
	input logic busy,
	input fpm_data_pkg::exp_req_t req,
	output fpm_op_pkg::op_sel_t op_sel,
	output fpm_data_pkg::opexp_t exp_a,
	output fpm_data_pkg::opexp_t exp_b
);

	fpm_op_pkg::op_code_e op_q;
	logic take;

	assign take = start & ~busy;

	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			op_q <= fpm_op_pkg::ad;
		end else if (take) begin
			op_q <= req.op;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			exp_a <= req.exp_a;
			exp_b <= req.exp_b;
		end
	end

	// one-hot decode like the 3-to-8 decoder on ir[7:9]
	always_comb begin
		op_sel = '0;
		case (op_q)
			fpm_op_pkg::ad: op_sel.ad = 1'b1;
			fpm_op_pkg::sd: op_sel.sd = 1'b1;
			fpm_op_pkg::mw: op_sel.mw = 1'b1;
			fpm_op_pkg::dw: op_sel.dw = 1'b1;
			fpm_op_pkg::af: op_sel.af = 1'b1;
			fpm_op_pkg::sf: op_sel.sf = 1'b1;
			fpm_op_pkg::mf: op_sel.mf = 1'b1;
			default: op_sel.df = 1'b1;
		endcase
		op_sel.ff = op_q[2];
		op_sel.ss = ~op_q[2];
	end

	// class is one-hot and matches the request taken one cycle earlier
	a_class_onehot: assert property (@(posedge clk_sys) disable iff (_0_f)
		take |=> ({op_sel.ad, op_sel.sd, op_sel.mw, op_sel.dw, op_sel.af, op_sel.sf,
			op_sel.mf, op_sel.df} == (8'h80 >> $past(req.op)))
			&& (op_sel.ff == $past(req.op[2])) && (op_sel.ss == !$past(req.op[2])));

endmodule

/* design/fpm_exp_path.sv */
// D and B exponent registers with the 10-bit exponent adder
// both registers load on the load strobe and sum follows them combinationally

`timescale 1ns/1ps

`include "fpm_macros.svh"

module fpm_exp_path(
	input logic clk_sys,
	input logic _0_f,
	input fpm_data_pkg::phase_t phase,
	input fpm_op_pkg::op_sel_t op_sel,
	input fpm_data_pkg::opexp_t exp_a,
	input fpm_data_pkg::opexp_t exp_b,
	output fpm_data_pkg::exp_t sum
);

	fpm_data_pkg::exp_t d_q;
	fpm_data_pkg::exp_t b_q;
	fpm_data_pkg::exp_t a_ext;
	fpm_data_pkg::exp_t b_ext;
	logic sub;
	logic sub_q;

	// af, sf and df all subtract exp_b from exp_a
	assign sub = op_sel.af | op_sel.sf | op_sel.df;

	// sign extension into the guard bits
	assign a_ext = fpm_data_pkg::exp_t'(exp_a);
	assign b_ext = fpm_data_pkg::exp_t'(exp_b);

	// carry-in for the two's complement of B
	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			sub_q <= 1'b0;
		end else if (phase.load) begin
			sub_q <= sub;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (phase.load) begin
			d_q <= a_ext;
			// B enters inverted when subtracting
			b_q <= sub ? ~b_ext : b_ext;
		end
	end

	// top three bits show whether the result left the 8-bit range
	assign sum = d_q + b_q + {{(`FPM_EXP_W+1){1'b0}}, sub_q};

endmodule

/* design/fpm_shift_counter.sv */
// alignment shift counter (FIC)
// loaded with the shift count on eval and stepped down once per
// alignment shift that the mantissa shifter does not hold off

`timescale 1ns/1ps

`include "fpm_macros.svh"

module fpm_shift_counter(
	input logic clk_sys,
	input logic _0_f,
	input logic cnt_load,
	input logic [`FPM_FIC_W-1:0] cnt_value,
	input logic step,
	input logic align_hold,
	output logic cnt_zero,
	output logic [`FPM_FIC_W-1:0] cnt
);

	logic [`FPM_FIC_W-1:0] cnt_nxt;
	logic dec;

	assign dec = step & ~align_hold;

	always_comb begin
		cnt_nxt = cnt;
		if (cnt_load) begin
			cnt_nxt = cnt_value;
		end else if (dec) begin
			cnt_nxt = cnt - 1'b1;
		end
	end

	// zero after this cycle, so the sequencer can leave on the last shift
	assign cnt_zero = (cnt_nxt == '0);

	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			cnt <= '0;
		end else begin
			cnt <= cnt_nxt;
		end
	end

	// the sequencer must stop stepping once the count is used up
	a_no_underflow: assert property (@(posedge clk_sys) disable iff (_0_f)
		dec |-> cnt != '0);

endmodule

/* design/fpm_sequencer.sv */
// microstep sequencer for one exponent operation
// steps through idle, load, eval, any align steps and fin with one strobe per step
// align is entered only for af/sf with a nonzero shift count

`timescale 1ns/1ps

module fpm_sequencer(
	input logic clk_sys,
	input logic _0_f,
	input logic start,
	input logic need_align,
	input logic cnt_zero,
	input logic align_hold,
	output logic busy,
	output fpm_data_pkg::phase_t phase
);

	typedef enum logic [2:0] {
		st_idle,
		st_load,
		st_eval,
		st_align,
		st_fin
	} state_e;

	state_e state;
	state_e state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: if (start) state_nxt = st_load;
			st_load: state_nxt = st_eval;
			st_eval: state_nxt = need_align ? st_align : st_fin;
			// cnt_zero only goes high on an unheld last shift
			st_align: if (cnt_zero && !align_hold) state_nxt = st_fin;
			st_fin: state_nxt = st_idle;
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	assign busy = (state != st_idle);

	always_comb begin
		phase.load = (state == st_load);
		phase.eval = (state == st_eval);
		phase.step = (state == st_align);
		phase.fin = (state == st_fin);
	end

	// fin only after a busy cycle that left the shift counter empty
	a_fin_not_idle: assert property (@(posedge clk_sys) disable iff (_0_f)
		phase.fin |-> $past(busy) && $past(cnt_zero));

endmodule

/* design/fpm_indicators.sv */
// indicator and result logic for the exponent unit
// works on the adder output during eval: g/wdt/wt for af/sf, range check
// for mf/df, and the alignment count handed to the shift counter

`timescale 1ns/1ps

`include "fpm_macros.svh"

module fpm_indicators(
	input logic clk_sys,
	input logic _0_f,
	input fpm_data_pkg::phase_t phase,
	input fpm_op_pkg::op_sel_t op_sel,
	input fpm_data_pkg::opexp_t exp_a,
	input fpm_data_pkg::opexp_t exp_b,
	input fpm_data_pkg::exp_t sum,
	output logic need_align,
	output logic cnt_load,
	output logic [`FPM_FIC_W-1:0] cnt_value,
	output fpm_data_pkg::exp_res_t res
);

	fpm_data_pkg::exp_res_t res_nxt;
	logic af_sf;
	logic mf_df;
	logic neg;
	logic ge_lim;
	logic [`FPM_EXP_W+1:0] mag;
	logic [`FPM_FIC_W-1:0] shift_cnt;

	assign af_sf = op_sel.af | op_sel.sf;
	assign mf_df = op_sel.mf | op_sel.df;

	// magnitude of the sum, 256 still fits unsigned
	assign neg = sum[`FPM_EXP_W+1];
	assign mag = neg ? -sum : sum;
	assign ge_lim = (mag >= (`FPM_EXP_W+2)'(`FPM_ALIGN_LIMIT));

	// no shifting when too far apart or already aligned
	assign shift_cnt = (ge_lim || sum == '0) ? '0 : mag[`FPM_FIC_W-1:0];

	always_comb begin
		res_nxt = '0;
		res_nxt.ff = op_sel.ff;
		if (af_sf) begin
			// larger exponent wins
			res_nxt.exp = neg ? exp_b : exp_a;
			res_nxt.g = ge_lim;
			res_nxt.wdt = neg;
			res_nxt.wt = ge_lim & ~neg;
			res_nxt.shifts = shift_cnt;
		end else if (mf_df) begin
			res_nxt.exp = sum[`FPM_EXP_W-1:0];
			// top three bits: 001..011 overflow, 100..110 underflow
			res_nxt.fi2 = ~sum[9] & (sum[8] | sum[7]);
			res_nxt.fi1 = sum[9] & ~(sum[8] & sum[7]);
		end
	end

	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			res <= '0;
		end else if (phase.eval) begin
			res <= res_nxt;
		end
	end

	// counter gets the count in the same cycle the indicators latch
	assign cnt_load = phase.eval;
	assign cnt_value = af_sf ? shift_cnt : '0;
	assign need_align = af_sf & (shift_cnt != '0);

endmodule

/* design/fpm_top.sv */
// top of the exponent unit: one request at a time under a start/busy rule
// done pulses with res valid, align_hold from the mantissa shifter stretches
// the alignment phase without changing the result

`timescale 1ns/1ps

`include "fpm_macros.svh"

module fpm_top(
	input logic clk_sys,
	input logic _0_f,
	input logic start,
	input fpm_data_pkg::exp_req_t req,
	input logic align_hold,
	output logic busy,
	output logic done,
	output fpm_data_pkg::exp_res_t res
);

	fpm_op_pkg::op_sel_t op_sel;
	fpm_data_pkg::opexp_t exp_a;
	fpm_data_pkg::opexp_t exp_b;
	fpm_data_pkg::phase_t phase;
	fpm_data_pkg::exp_t sum;
	logic need_align;
	logic cnt_zero;
	logic cnt_load;
	logic [`FPM_FIC_W-1:0] cnt_value;
	logic [`FPM_FIC_W-1:0] cnt;

	fpm_op_regs op_regs_i(.clk_sys(clk_sys), ._0_f(_0_f), .start(start),
		.busy(busy), .req(req), .op_sel(op_sel), .exp_a(exp_a), .exp_b(exp_b));

	fpm_exp_path exp_path_i(.clk_sys(clk_sys), ._0_f(_0_f), .phase(phase),
		.op_sel(op_sel), .exp_a(exp_a), .exp_b(exp_b), .sum(sum));

	fpm_shift_counter shift_counter_i(.clk_sys(clk_sys), ._0_f(_0_f),
		.cnt_load(cnt_load), .cnt_value(cnt_value), .step(phase.step),
		.align_hold(align_hold), .cnt_zero(cnt_zero), .cnt(cnt));

	fpm_sequencer sequencer_i(.clk_sys(clk_sys), ._0_f(_0_f), .start(start),
		.need_align(need_align), .cnt_zero(cnt_zero), .align_hold(align_hold),
		.busy(busy), .phase(phase));

	fpm_indicators indicators_i(.clk_sys(clk_sys), ._0_f(_0_f), .phase(phase),
		.op_sel(op_sel), .exp_a(exp_a), .exp_b(exp_b), .sum(sum),
		.need_align(need_align), .cnt_load(cnt_load), .cnt_value(cnt_value),
		.res(res));

	assign done = phase.fin;

	// all alignment shifts are done by the time the result is reported
	a_done_cnt_empty: assert property (@(posedge clk_sys) disable iff (_0_f)
		done |-> cnt == '0 && $past(busy));

	// a start while busy is dropped by the request register
	a_start_idle: assert property (@(posedge clk_sys) disable iff (_0_f)
		not (start && busy)) else $warning("start while busy ignored");

endmodule

/* sim/fpm_tb.sv */
// testbench for the exponent unit: random and edge requests through fpm_top
// a reference model predicts each result at acceptance, concurrent
// assertions compare res and the done timing against it

`timescale 1ns/1ps

`include "fpm_macros.svh"

module fpm_tb;

	localparam int N_ALIGN = 40;
	localparam int N_FAR = 10;
	localparam int N_EDGE = 6;
	localparam int N_MUL = 20;
	localparam int N_FIX = 8;
	localparam int N_HOLD = 30;
	// directed near, far and busy-start requests are the 4 + 8 + 2
	localparam int N_REQ = N_ALIGN + 4 + 8 + N_FAR + 2 * N_EDGE * N_EDGE + N_MUL
		+ N_FIX + 2 + N_HOLD;
	localparam int TIMEOUT = N_REQ * 50 + 200;

	logic clk_sys;
	logic _0_f;
	logic start;
	logic align_hold;
	fpm_data_pkg::exp_req_t req;
	logic busy;
	logic done;
	fpm_data_pkg::exp_res_t res;

	integer seed;
	fpm_data_pkg::exp_res_t exp_res;
	int elapsed;
	int held;
	int exp_latency;
	int cycles;
	int n_acc;
	int n_done;
	int issued;
	int err_count;
	logic accepted_any;
	int edge_vals [N_EDGE] = '{127, -128, -127, 0, 1, -1};

	fpm_top fpm_top_i(.clk_sys(clk_sys), ._0_f(_0_f), .start(start), .req(req),
		.align_hold(align_hold), .busy(busy), .done(done), .res(res));

	always #4 clk_sys = ~clk_sys;

	// expected result from the operation rules
	function automatic fpm_data_pkg::exp_res_t model_result(input fpm_data_pkg::exp_req_t r);
		fpm_data_pkg::exp_res_t m;
		int a;
		int b;
		int d;
		int mag;
		int s;
		m = '0;
		a = $signed(r.exp_a);
		b = $signed(r.exp_b);
		m.ff = r.op[2];
		case (r.op)
			fpm_op_pkg::af, fpm_op_pkg::sf: begin
				d = a - b;
				mag = (d < 0) ? -d : d;
				m.g = (mag >= `FPM_ALIGN_LIMIT);
				m.wdt = (d < 0);
				m.wt = m.g && (d > 0);
				m.shifts = (m.g || d == 0) ? '0 : mag[`FPM_FIC_W-1:0];
				m.exp = (a >= b) ? r.exp_a : r.exp_b;
			end
			fpm_op_pkg::mf, fpm_op_pkg::df: begin
				s = (r.op == fpm_op_pkg::mf) ? a + b : a - b;
				m.exp = s[7:0];
				m.fi2 = (s > 127);
				m.fi1 = (s < -128);
			end
			default: ;
		endcase
		return m;
	endfunction

	// acceptance tracking, latency and held alignment cycles
	always @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			exp_res <= '0;
			elapsed <= 0;
			held <= 0;
			cycles <= 0;
			n_acc <= 0;
			n_done <= 0;
			accepted_any <= 1'b0;
		end else begin
			cycles <= cycles + 1;
			if (start && !busy) begin
				exp_res <= model_result(req);
				elapsed <= 1;
				held <= 0;
				accepted_any <= 1'b1;
				n_acc <= n_acc + 1;
			end else if (busy) begin
				elapsed <= elapsed + 1;
				// from the cycle after eval until fin the unit is aligning
				if (elapsed >= 3 && exp_res.shifts != 0 && !done && align_hold)
					held <= held + 1;
			end
			if (done)
				n_done <= n_done + 1;
		end
	end

	assign exp_latency = 3 + exp_res.shifts + held;

	reset_quiet: assert property (@(posedge clk_sys) disable iff (_0_f)
		!accepted_any |-> !busy && !done)
		else begin
			err_count++;
			$display("busy or done raised before the first request");
		end

	reset_res: assert property (@(posedge clk_sys) disable iff (_0_f)
		!accepted_any |-> res == '0)
		else begin
			err_count++;
			$display("Error res after reset: got %h expected %h", $sampled(res), 15'h0);
		end

	result_value: assert property (@(posedge clk_sys) disable iff (_0_f)
		done |-> res == exp_res)
		else begin
			err_count++;
			$display("Error res: got %h expected %h", $sampled(res), $sampled(exp_res));
		end

	done_latency: assert property (@(posedge clk_sys) disable iff (_0_f)
		done |-> elapsed == exp_latency)
		else begin
			err_count++;
			$display("Error done latency: got %h expected %h", $sampled(elapsed),
				$sampled(exp_latency));
		end

	idle_stable: assert property (@(posedge clk_sys) disable iff (_0_f)
		!busy |=> $stable(res))
		else begin
			err_count++;
			$display("result changed while the unit was idle");
		end

	done_single: assert property (@(posedge clk_sys) disable iff (_0_f)
		done |=> !done && !busy)
		else begin
			err_count++;
			$display("done lasted more than one cycle or busy stayed high after it");
		end

	busy_after_take: assert property (@(posedge clk_sys) disable iff (_0_f)
		(start && !busy) |=> busy)
		else begin
			err_count++;
			$display("request was not taken, busy did not rise");
		end

	always @(posedge clk_sys) begin
		if (cycles >= TIMEOUT) begin
			$display("run did not finish within %0d cycles", TIMEOUT);
			$display("test failed");
			$finish;
		end
	end

	function automatic int rand_exp();
		logic signed [7:0] v;
		v = $random(seed);
		return v;
	endfunction

	// one request, optionally with random hold and a second start while busy
	task automatic run_op(input fpm_op_pkg::op_code_e op, input int a, input int b,
		input bit hold_en, input bit poke_busy);
		int r;
		@(negedge clk_sys);
		while (busy)
			@(negedge clk_sys);
		req.op = op;
		req.exp_a = a[7:0];
		req.exp_b = b[7:0];
		start = 1'b1;
		issued++;
		@(negedge clk_sys);
		if (poke_busy) begin
			// different request held over load and eval, must be dropped
			req.op = fpm_op_pkg::op_code_e'(~req.op);
			req.exp_a = ~req.exp_a;
			repeat (2) @(negedge clk_sys);
		end
		start = 1'b0;
		while (!done) begin
			r = $random(seed);
			align_hold = hold_en & r[0];
			@(negedge clk_sys);
		end
		align_hold = 1'b0;
	endtask

	// af/sf with |diff| below the alignment limit
	task automatic run_near(input bit hold_en);
		int a;
		int b;
		int off;
		int r;
		a = rand_exp();
		off = $random(seed) % 40;
		b = a - off;
		if (b > 127 || b < -128)
			b = a + off;
		r = $random(seed);
		run_op(r[0] ? fpm_op_pkg::sf : fpm_op_pkg::af, a, b, hold_en, 1'b0);
	endtask

	initial begin
		int r;
		seed = 32'hd5d1;
		clk_sys = 1'b0;
		_0_f = 1'b1;
		start = 1'b0;
		align_hold = 1'b0;
		req = '0;
		issued = 0;
		err_count = 0;
		repeat (8) @(negedge clk_sys);
		_0_f = 1'b0;
		repeat (4) @(negedge clk_sys);

		// alignment within range, boundary at 39 first
		run_op(fpm_op_pkg::af, 39, 0, 1'b0, 1'b0);
		run_op(fpm_op_pkg::sf, 0, 39, 1'b0, 1'b0);
		run_op(fpm_op_pkg::af, -128, -89, 1'b0, 1'b0);
		run_op(fpm_op_pkg::sf, 100, 61, 1'b0, 1'b0);
		repeat (N_ALIGN) run_near(1'b0);

		// equal exponents and differences at or past the limit
		run_op(fpm_op_pkg::af, 5, 5, 1'b0, 1'b0);
		run_op(fpm_op_pkg::sf, -128, -128, 1'b0, 1'b0);
		run_op(fpm_op_pkg::af, 40, 0, 1'b0, 1'b0);
		run_op(fpm_op_pkg::sf, 0, 40, 1'b0, 1'b0);
		run_op(fpm_op_pkg::af, 127, -128, 1'b0, 1'b0);
		run_op(fpm_op_pkg::sf, -128, 127, 1'b0, 1'b0);
		run_op(fpm_op_pkg::af, 100, -50, 1'b0, 1'b0);
		run_op(fpm_op_pkg::sf, -60, 0, 1'b0, 1'b0);
		repeat (N_FAR) begin
			r = $random(seed);
			run_op(r[0] ? fpm_op_pkg::sf : fpm_op_pkg::af, rand_exp(), rand_exp(),
				1'b0, 1'b0);
		end

		// multiply and divide exponents, edges then random
		for (int i = 0; i < N_EDGE; i++) begin
			for (int j = 0; j < N_EDGE; j++) begin
				run_op(fpm_op_pkg::mf, edge_vals[i], edge_vals[j], 1'b0, 1'b0);
				run_op(fpm_op_pkg::df, edge_vals[i], edge_vals[j], 1'b0, 1'b0);
			end
		end
		repeat (N_MUL) begin
			r = $random(seed);
			run_op(r[0] ? fpm_op_pkg::df : fpm_op_pkg::mf, rand_exp(), rand_exp(),
				1'b0, 1'b0);
		end

		// fixed point, each with an ignored start while busy
		repeat (N_FIX) begin
			r = $random(seed);
			run_op(fpm_op_pkg::op_code_e'({1'b0, r[1:0]}), rand_exp(), rand_exp(),
				1'b0, 1'b1);
		end
		run_op(fpm_op_pkg::af, 20, -3, 1'b0, 1'b1);
		run_op(fpm_op_pkg::mf, 90, 60, 1'b0, 1'b1);

		// shifter back-pressure during alignment
		repeat (N_HOLD) run_near(1'b1);

		repeat (4) @(negedge clk_sys);
		request_count: assert (n_acc == issued && n_done == issued)
			else begin
				err_count++;
				$display("Error done count: got %h expected %h", n_done, issued);
			end
		$display("%0d requests, %0d results, %0d errors", n_acc, n_done, err_count);
		if (err_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+design
design/fpm_op_pkg.sv
design/fpm_data_pkg.sv
design/fpm_op_regs.sv
design/fpm_exp_path.sv
design/fpm_shift_counter.sv
design/fpm_sequencer.sv
design/fpm_indicators.sv
design/fpm_top.sv
sim/fpm_tb.sv
